// File: hdl/bridge_defines.svh
`ifndef BRIDGE_DEFINES_SVH
`define BRIDGE_DEFINES_SVH

`define ADDR_WIDTH 32
`define DATA_WIDTH 32

`define NUM_SLAVES 3
`define REG_DEPTH 16

// peripheral regions, 64 MB each
`define SLAVE_BASE0 32'h8000_0000
`define SLAVE_BASE1 32'h8400_0000
`define SLAVE_BASE2 32'h8800_0000
`define REGION_BITS 26

`endif

// File: hdl/bridgePkg.sv
`default_nettype none
`include "bridge_defines.svh"

package bridgePkg;

	typedef enum logic [1:0]
	{
		IDLE   = 2'b00,
		BUSY   = 2'b01,
		NONSEQ = 2'b10,
		SEQ    = 2'b11
	} htransT;

	typedef enum logic [2:0]
	{
		stIdle     = 3'b000,
		stWwait    = 3'b001,
		stRead     = 3'b010,
		stWrite    = 3'b011,
		stWritep   = 3'b100,
		stRenable  = 3'b101,
		stWenable  = 3'b110,
		stWenablep = 3'b111
	} apbStateT;

	typedef logic [`ADDR_WIDTH-1:0] addrT;
	typedef logic [`DATA_WIDTH-1:0] dataT;
	typedef logic [`NUM_SLAVES-1:0] selT; // one-hot peripheral select

endpackage

`default_nettype wire

// File: hdl/ahbSlaveInterface.sv
`timescale 1ns/10ps
`default_nettype none
`include "bridge_defines.svh"

module ahbSlaveInterface
(
	input  wire logic              Hclk,
	input  wire logic              Hresetn,
	input  wire logic              Hwrite,
	input  wire logic              Hreadyin,
	input  wire bridgePkg::htransT Htrans,
	input  wire bridgePkg::addrT   Haddr,
	input  wire bridgePkg::dataT   Hwdata,
	output logic                   valid,
	output logic                   Hwritereg,
	output bridgePkg::addrT        Haddr1,
	output bridgePkg::addrT        Haddr2,
	output bridgePkg::dataT        Hwdata1,
	output bridgePkg::selT         tempSel
);
	import bridgePkg::*;

	localparam addrT regionBase [`NUM_SLAVES] = '{`SLAVE_BASE0, `SLAVE_BASE1, `SLAVE_BASE2};

	logic activeTrans;

	// BUSY and IDLE never start a transfer
	assign activeTrans = (Htrans == NONSEQ) || (Htrans == SEQ);

	always_comb
	begin
		for (int i = 0; i < `NUM_SLAVES; i++)
		begin
			tempSel[i] = (Haddr[`ADDR_WIDTH-1:`REGION_BITS] ==
				regionBase[i][`ADDR_WIDTH-1:`REGION_BITS]);
		end
	end

	// unmapped addresses never reach the controller
	assign valid = Hreadyin && activeTrans && (|tempSel);

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
			Hwritereg <= 1'b0;
		else if (valid)
			Hwritereg <= Hwrite; // direction of newest accepted transfer
	end

	// two-deep address pipeline, shifts only on accepted transfers
	always_ff @(posedge Hclk)
	begin
		if (valid)
		begin
			Haddr1 <= Haddr;
			Haddr2 <= Haddr1;
		end
	end

	always_ff @(posedge Hclk)
	begin
		if (Hreadyin)
			Hwdata1 <= Hwdata; // data phase completes on this edge
	end

endmodule

`default_nettype wire

// File: hdl/apbController.sv
`timescale 1ns/10ps
`default_nettype none
`include "bridge_defines.svh"

module apbController
(
	input  wire logic            Hclk,
	input  wire logic            Hresetn,
	input  wire logic            valid,
	input  wire logic            Hwrite,
	input  wire logic            Hwritereg,
	input  wire bridgePkg::addrT Haddr,
	input  wire bridgePkg::addrT Haddr1,
	input  wire bridgePkg::addrT Haddr2,
	input  wire bridgePkg::dataT Hwdata,
	input  wire bridgePkg::dataT Hwdata1,
	input  wire bridgePkg::selT  tempSel,
	output logic                 Pwrite,
	output logic                 Penable,
	output bridgePkg::selT       Psel,
	output bridgePkg::addrT      Paddr,
	output bridgePkg::dataT      Pwdata,
	output logic                 Hreadyout
);
	import bridgePkg::*;

	apbStateT state, nextState;
	selT sel1, sel2;
	logic twoPending;
	logic pwriteNext, penableNext, readyNext;
	selT pselNext;
	addrT paddrNext;
	dataT pwdataNext;

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
			state <= stIdle;
		else
			state <= nextState;
	end

	// selects follow the interface address pipeline
	always_ff @(posedge Hclk)
	begin
		if (valid)
		begin
			sel1 <= tempSel;
			sel2 <= sel1;
		end
	end

	// a second transfer was taken while the pending write finished its data phase
	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
			twoPending <= 1'b0;
		else if (state == stWritep)
			twoPending <= valid;
	end

	always_comb
	begin
		nextState = stIdle;
		case (state)
			stIdle, stRenable, stWenable:
			begin
				if (valid)
					nextState = Hwrite ? stWwait : stRead;
			end
			stWwait:    nextState = valid ? stWritep : stWrite;
			stRead:     nextState = stRenable;
			stWrite:    nextState = stWenable;
			stWritep:   nextState = stWenablep;
			stWenablep:
			begin
				if (twoPending)
					nextState = stWritep;
				else if (Hwritereg)
					nextState = stWrite;
				else
					nextState = stRead;
			end
			default:    nextState = stIdle;
		endcase
	end

	always_comb
	begin
		pselNext = Psel;
		penableNext = 1'b0;
		pwriteNext = Pwrite;
		paddrNext = Paddr;
		pwdataNext = Pwdata;
		readyNext = 1'b1;
		case (state)
			stIdle, stRenable, stWenable:
			begin
				pselNext = '0;
				if (valid && !Hwrite)
				begin
					pselNext = tempSel; // read setup straight from the bus
					pwriteNext = 1'b0;
					paddrNext = Haddr;
					readyNext = 1'b0;
				end
			end
			stWwait:
			begin
				pselNext = sel1;
				pwriteNext = 1'b1;
				paddrNext = Haddr1;
				pwdataNext = Hwdata;
				readyNext = valid && Hwrite; // a pending read must wait
			end
			stRead, stWrite:
				penableNext = 1'b1;
			stWritep:
			begin
				penableNext = 1'b1;
				readyNext = 1'b0;
			end
			stWenablep:
			begin
				pwriteNext = twoPending || Hwritereg;
				readyNext = twoPending && Hwritereg;
				pwdataNext = Hwdata1;
				if (twoPending)
				begin
					pselNext = sel2; // older write sits behind the newest one
					paddrNext = Haddr2;
				end
				else
				begin
					pselNext = sel1;
					paddrNext = Haddr1;
				end
			end
			default:
				pselNext = '0;
		endcase
	end

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			Psel <= '0;
			Penable <= 1'b0;
			Pwrite <= 1'b0;
			Hreadyout <= 1'b1;
		end
		else
		begin
			Psel <= pselNext;
			Penable <= penableNext;
			Pwrite <= pwriteNext;
			Hreadyout <= readyNext;
		end
	end

	always_ff @(posedge Hclk)
	begin
		Paddr <= paddrNext;
		Pwdata <= pwdataNext;
	end

endmodule

`default_nettype wire

// File: hdl/apbRegSlave.sv
`timescale 1ns/10ps
`default_nettype none
`include "bridge_defines.svh"

module apbRegSlave
(
	input  wire logic            Hclk,
	input  wire logic            Hresetn,
	input  wire logic            psel,
	input  wire logic            Penable,
	input  wire logic            Pwrite,
	input  wire bridgePkg::addrT Paddr,
	input  wire bridgePkg::dataT Pwdata,
	output bridgePkg::dataT      Prdata
);
	import bridgePkg::*;

	localparam int idxBits = $clog2(`REG_DEPTH);

	dataT regFile [`REG_DEPTH];
	logic [idxBits-1:0] regIdx;

	assign regIdx = Paddr[idxBits+1:2]; // word addressed

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			for (int i = 0; i < `REG_DEPTH; i++)
				regFile[i] <= '0;
		end
		else if (psel && Penable && Pwrite)
		begin
			regFile[regIdx] <= Pwdata; // commit at end of enable
		end
	end

	// zero when idle so the mux can simply OR the slaves
	assign Prdata = psel ? regFile[regIdx] : '0;

endmodule

`default_nettype wire

// File: hdl/readDataMux.sv
`timescale 1ns/10ps
`default_nettype none
`include "bridge_defines.svh"

module readDataMux
(
	input  wire bridgePkg::selT  Psel,
	input  wire bridgePkg::dataT Prdata [`NUM_SLAVES],
	input  wire logic            Hclk,
	input  wire logic            Hresetn,
	output bridgePkg::dataT      Hrdata
);
	import bridgePkg::*;

	dataT selData;
	dataT heldData;

	always_comb
	begin
		selData = '0;
		for (int i = 0; i < `NUM_SLAVES; i++)
		begin
			if (Psel[i])
				selData = selData | Prdata[i];
		end
	end

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
			heldData <= '0;
		else if (|Psel)
			heldData <= selData; // last value seen on the APB side
	end

	assign Hrdata = (|Psel) ? selData : heldData;

endmodule

`default_nettype wire

// File: hdl/bridgeTop.sv
`timescale 1ns/10ps
`default_nettype none
`include "bridge_defines.svh"

module bridgeTop
(
	input  wire logic              Hclk,
	input  wire logic              Hresetn,
	input  wire logic              Hwrite,
	input  wire logic              Hreadyin,
	input  wire bridgePkg::htransT Htrans,
	input  wire bridgePkg::addrT   Haddr,
	input  wire bridgePkg::dataT   Hwdata,
	output wire logic              Hreadyout,
	output wire bridgePkg::dataT   Hrdata
);
	import bridgePkg::*;

	logic valid;
	logic Hwritereg;
	logic Pwrite;
	logic Penable;
	addrT Haddr1;
	addrT Haddr2;
	addrT Paddr;
	dataT Hwdata1;
	dataT Pwdata;
	selT tempSel;
	selT Psel;
	dataT Prdata [`NUM_SLAVES];

	ahbSlaveInterface uAhbIf
	(
		.Hclk, .Hresetn, .Hwrite, .Hreadyin, .Htrans, .Haddr, .Hwdata,
		.valid, .Hwritereg, .Haddr1, .Haddr2, .Hwdata1, .tempSel
	);

	apbController uCtrl
	(
		.Hclk, .Hresetn, .valid, .Hwrite, .Hwritereg, .Haddr, .Haddr1, .Haddr2,
		.Hwdata, .Hwdata1, .tempSel,
		.Pwrite, .Penable, .Psel, .Paddr, .Pwdata, .Hreadyout
	);

	for (genvar i = 0; i < `NUM_SLAVES; i++)
	begin : gSlave
		apbRegSlave uSlave
		(
			.Hclk, .Hresetn, .psel(Psel[i]), .Penable, .Pwrite, .Paddr, .Pwdata,
			.Prdata(Prdata[i])
		);
	end

	readDataMux uMux
	(
		.Psel, .Prdata, .Hclk, .Hresetn, .Hrdata
	);

endmodule

`default_nettype wire

// File: tb/bridgeTb.sv
`timescale 1ns/10ps
`default_nettype none
`include "bridge_defines.svh"

module bridgeTb;
	import bridgePkg::*;

	localparam int timeoutCycles = 50;
	localparam addrT unmappedBase = 32'h9000_0000;
	localparam addrT regionSize = 32'h0400_0000;
	localparam addrT slaveBase [`NUM_SLAVES] = '{`SLAVE_BASE0, `SLAVE_BASE1, `SLAVE_BASE2};

	typedef struct packed
	{
		logic write;
		addrT addr;
		dataT data;
		dataT expData;
	} stimRowT;

	logic Hclk;
	logic Hresetn;
	logic Hwrite;
	logic Hreadyin;
	htransT Htrans;
	addrT Haddr;
	dataT Hwdata;
	logic Hreadyout;
	dataT Hrdata;

	stimRowT stim [$];
	dataT shadow [`NUM_SLAVES][`REG_DEPTH]; // reference copy of the register files
	dataT lastRead;
	logic [31:0] rngState;
	logic pendValid; // a data phase is still open
	logic pendUnmapped;
	stimRowT pendRow;

	assign Hreadyin = Hresetn ? Hreadyout : 1'b1; // master follows the bridge's ready

	bridgeTop u_dut
	(
		.Hclk, .Hresetn, .Hwrite, .Hreadyin, .Htrans, .Haddr, .Hwdata,
		.Hreadyout, .Hrdata
	);

	always
	begin
		#4 Hclk = ~Hclk;
	end

	function automatic logic [31:0] nextRand();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	function automatic int regionOf(input addrT addr);
		int region;
		region = -1;
		for (int k = 0; k < `NUM_SLAVES; k++)
		begin
			if (addr >= slaveBase[k] && addr < slaveBase[k] + regionSize)
				region = k;
		end
		return region;
	endfunction

	function automatic addrT wordAddr(input int slave, input int word);
		return slaveBase[slave] + addrT'(word << 2);
	endfunction

	function automatic addrT randAddr();
		int slave;
		slave = int'(nextRand() % 32'd3);
		return slaveBase[slave] | (nextRand() & 32'h03FF_FFFC);
	endfunction

	function automatic void addWrite(input addrT addr, input dataT data);
		stimRowT row;
		int region;
		region = regionOf(addr);
		if (region >= 0)
			shadow[region][addr[5:2]] = data;
		row.write = 1'b1;
		row.addr = addr;
		row.data = data;
		row.expData = '0;
		stim.push_back(row);
	endfunction

	function automatic void addRead(input addrT addr);
		stimRowT row;
		int region;
		region = regionOf(addr);
		if (region >= 0)
			lastRead = shadow[region][addr[5:2]];
		row.write = 1'b0;
		row.addr = addr;
		row.data = '0;
		row.expData = lastRead; // an unmapped read sees the value held by the mux
		stim.push_back(row);
	endfunction

	function automatic void buildStim();
		addrT addr;
		for (int s = 0; s < `NUM_SLAVES; s++)
			for (int w = 0; w < `REG_DEPTH; w++)
				addRead(wordAddr(s, w)); // all clear after reset
		for (int s = 0; s < `NUM_SLAVES; s++)
		begin
			addWrite(wordAddr(s, 5), 32'hA5A5_0000 + dataT'(s));
			for (int o = 0; o < `NUM_SLAVES; o++)
				addRead(wordAddr(o, 5));
		end
		for (int k = 0; k < 6; k++)
			addWrite(wordAddr(k % `NUM_SLAVES, 8 + k), (32'h1000_0001 << k) ^ 32'h00C0_FFEE);
		for (int k = 0; k < 6; k++)
			addRead(wordAddr(k % `NUM_SLAVES, 8 + k));
		addRead(wordAddr(1, 5));
		addWrite(unmappedBase + 32'h14, 32'hDEAD_BEEF);
		addRead(unmappedBase + 32'h14);
		for (int s = 0; s < `NUM_SLAVES; s++)
			addRead(wordAddr(s, 5));
		for (int k = 0; k < 20; k++)
		begin
			addr = randAddr();
			addWrite(addr, nextRand());
			if (nextRand() & 32'd1)
				addRead(addr);
			else
				addRead(randAddr());
		end
	endfunction

	task automatic failRun();
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic checkData(input dataT actual, input dataT expected, input addrT addr);
		if (actual !== expected)
		begin
			$display("Error at %0t ns: read of %h returned %h, expected %h",
				$time, addr, actual, expected);
			failRun();
		end
	endtask

	task automatic checkReady(input logic actual, input logic expected);
		if (actual !== expected)
		begin
			$display("Error at %0t ns: Hreadyout is %b, expected %b", $time, actual, expected);
			failRun();
		end
	endtask

	// stops at the negedge before the first edge that has Hreadyout high
	task automatic waitReady(input logic noStall);
		int cycles;
		cycles = 0;
		@(negedge Hclk);
		if (noStall)
			checkReady(Hreadyout, 1'b1);
		while (Hreadyout !== 1'b1)
		begin
			cycles++;
			if (cycles >= timeoutCycles)
			begin
				$display("Timeout at %0t ns: the bridge never became ready", $time);
				failRun();
			end
			@(negedge Hclk);
		end
	endtask

	task automatic completePending();
		waitReady(pendValid && pendUnmapped);
		if (pendValid && !pendRow.write)
			checkData(Hrdata, pendRow.expData, pendRow.addr);
		@(posedge Hclk);
		#1;
	endtask

	task automatic ahbWrite(input stimRowT row);
		Htrans = NONSEQ;
		Hwrite = 1'b1;
		Haddr = row.addr;
		completePending(); // same edge takes the new address
		Hwdata = row.data;
		pendValid = 1'b1;
		pendUnmapped = (regionOf(row.addr) < 0);
		pendRow = row;
	endtask

	task automatic ahbRead(input stimRowT row);
		Htrans = NONSEQ;
		Hwrite = 1'b0;
		Haddr = row.addr;
		completePending();
		pendValid = 1'b1;
		pendUnmapped = (regionOf(row.addr) < 0);
		pendRow = row;
	endtask

	task automatic idleBus();
		Htrans = IDLE;
		Hwrite = 1'b0;
		completePending();
		pendValid = 1'b0;
	endtask

	initial
	begin
		$timeformat(-9, 0, "", 0);
		Hclk = 1'b0;
		Hresetn = 1'b0;
		Hwrite = 1'b0;
		Htrans = IDLE;
		Haddr = '0;
		Hwdata = '0;
		pendValid = 1'b0;
		pendUnmapped = 1'b0;
		pendRow = '0;
		rngState = 32'd59;
		lastRead = '0;
		for (int s = 0; s < `NUM_SLAVES; s++)
			for (int w = 0; w < `REG_DEPTH; w++)
				shadow[s][w] = '0;
		buildStim();
		repeat (2) @(posedge Hclk);
		#1;
		Hresetn = 1'b1;
		@(negedge Hclk);
		checkReady(Hreadyout, 1'b1);
		@(posedge Hclk);
		#1;
		for (int i = 0; i < stim.size(); i++)
		begin
			if (stim[i].write)
				ahbWrite(stim[i]);
			else
				ahbRead(stim[i]);
		end
		idleBus();
		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
+incdir+hdl
hdl/bridgePkg.sv
hdl/ahbSlaveInterface.sv
hdl/apbController.sv
hdl/apbRegSlave.sv
hdl/readDataMux.sv
hdl/bridgeTop.sv
tb/bridgeTb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/10ps -Wno-fatal
TOP       = bridgeTb
FILELIST  = sources.f
OBJDIR    = obj_dir
PASS_MSG  = All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJDIR)
